// ==== logic/analog_params.svh ====
// widths, region map and housekeeping register offsets for the analog front end
`ifndef ANALOG_PARAMS_SVH
`define ANALOG_PARAMS_SVH

////////////////////////////////////////////////////////////
// data widths
////////////////////////////////////////////////////////////

`define ADC_W       14          // converter sample width
`define BUS_W       32          // system bus data and address

////////////////////////////////////////////////////////////
// system bus region map
////////////////////////////////////////////////////////////

`define REGION_N    8           // 1 MiB regions
`define REGION_LSB  20          // region field starts here

////////////////////////////////////////////////////////////
// housekeeping block, region 0
////////////////////////////////////////////////////////////

`define HK_ID_VALUE  32'h0A11_0001  // read-only board id
`define HK_OFS_ID    20'h00000
`define HK_OFS_LOOP  20'h0000C      // bit 0 = digital loop
`define HK_OFS_LED   20'h00030      // 8 LEDs
`define HK_OFS_DAC_A 20'h00040      // channel A setpoint
`define HK_OFS_DAC_B 20'h00044      // channel B setpoint

`endif

// ==== logic/analog_pkg.sv ====
// sample types, bus word type and the two-view system bus address union
`include "analog_params.svh"

package analog_pkg;

  // two's complement, as seen by the processing side
  typedef logic signed [`ADC_W-1:0] sample_t;

  // unsigned negative-slope code, as seen on the converter pins
  typedef logic [`ADC_W-1:0] raw_code_t;

  typedef logic [`BUS_W-1:0] bus_word_t;

  // split view of the address
  // upper bits are don't care, region picks the 1 MiB slot
  typedef struct packed {
    logic [`BUS_W-`REGION_LSB-$clog2(`REGION_N)-1:0] upper;
    logic [$clog2(`REGION_N)-1:0]                    region;  // slot select
    logic [`REGION_LSB-1:0]                          offset;  // byte offset in slot
  } sys_addr_fields_t;

  // decoder reads .f.region, hk block reads .f.offset
  typedef union packed {
    logic [`BUS_W-1:0] flat;
    sys_addr_fields_t  f;
  } sys_addr_u;

endpackage

// ==== logic/bus_decoder.sv ====
// system bus region decoder with enable fan-out, read mux and empty-slot answers
`timescale 1ns/100ps
`include "analog_params.svh"

module bus_decoder (
  input  logic                  adc_clk,      // assertion clock only
  input  logic                  rst_n_i,
  input  analog_pkg::sys_addr_u sys_addr_i,
  input  logic                  sys_wen_i,
  input  logic                  sys_ren_i,
  input  analog_pkg::bus_word_t hk_rdata_i,
  input  logic                  hk_ack_i,
  input  logic                  hk_err_i,
  output logic                  hk_wen_o,
  output logic                  hk_ren_o,
  output analog_pkg::bus_word_t sys_rdata_o,
  output logic                  sys_ack_o,
  output logic                  sys_err_o
);

  import analog_pkg::*;

  logic [`REGION_N-1:0] region_cs;        // one-hot slot select
  logic [`REGION_N-1:0] region_ack;
  logic [`REGION_N-1:0] region_err;
  bus_word_t            region_rdata [`REGION_N];
  logic                 sys_req;

  assign sys_req   = sys_wen_i | sys_ren_i;
  assign region_cs = {{(`REGION_N-1){1'b0}}, 1'b1} << sys_addr_i.f.region;

  // only slot 0 is populated
  assign hk_wen_o = region_cs[0] & sys_wen_i;
  assign hk_ren_o = region_cs[0] & sys_ren_i;

  // per-slot answers, empty slots ack at once with zero data
  always_comb
  begin
    for (int r = 0; r < `REGION_N; r++)
    begin
      region_rdata[r] = '0;
      region_ack[r]   = sys_req;  // same-cycle ack
      region_err[r]   = 1'b0;
    end
    region_rdata[0] = hk_rdata_i;
    region_ack[0]   = hk_ack_i;   // registered in hk block
    region_err[0]   = hk_err_i;
  end

  assign sys_rdata_o = region_rdata[sys_addr_i.f.region];
  assign sys_ack_o   = |(region_cs & region_ack);
  assign sys_err_o   = |(region_cs & region_err);

  // master holds the address until ack, so region 0 here
  // means the request a cycle back went to hk as well
  a_hk_ack_has_request : assert property (
    @(posedge adc_clk) disable iff (!rst_n_i)
    (sys_ack_o && region_cs[0]) |-> $past(hk_wen_o || hk_ren_o)
  ) else $error("region 0 ack without a region 0 request");

endmodule

// ==== logic/hk_regs.sv ====
// housekeeping registers on region 0: id, digital loop, LEDs and DAC setpoints
`timescale 1ns/100ps
`include "analog_params.svh"

module hk_regs (
  input  logic                  adc_clk,
  input  logic                  rst_n_i,
  input  analog_pkg::sys_addr_u sys_addr_i,
  input  analog_pkg::bus_word_t sys_wdata_i,
  input  logic                  wen_i,
  input  logic                  ren_i,
  output analog_pkg::bus_word_t rdata_o,
  output logic                  ack_o,
  output logic                  err_o,
  output logic                  digital_loop_o,
  output logic [7:0]            led_o,
  output analog_pkg::sample_t   dac_set_a_o,
  output analog_pkg::sample_t   dac_set_b_o
);

  import analog_pkg::*;

  bus_word_t rd_word;       // read mux result
  logic      ofs_hit;       // offset is a known register
  logic      ofs_ro;        // read-only offset
  logic      wr_ok;

  ////////////////////////////////////////////////////////////
  // offset decode and read mux
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    rd_word = '0;
    ofs_hit = 1'b1;
    ofs_ro  = 1'b0;
    case (sys_addr_i.f.offset)
      `HK_OFS_ID:    begin rd_word = `HK_ID_VALUE; ofs_ro = 1'b1; end
      `HK_OFS_LOOP:  rd_word = {{(`BUS_W-1){1'b0}}, digital_loop_o};
      `HK_OFS_LED:   rd_word = {{(`BUS_W-8){1'b0}}, led_o};
      // setpoints read back zero-extended, as written
      `HK_OFS_DAC_A: rd_word = {{(`BUS_W-`ADC_W){1'b0}}, dac_set_a_o};
      `HK_OFS_DAC_B: rd_word = {{(`BUS_W-`ADC_W){1'b0}}, dac_set_b_o};
      default:       ofs_hit = 1'b0;
    endcase
  end

  assign wr_ok = wen_i & ofs_hit & ~ofs_ro;

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      digital_loop_o <= 1'b0;
      led_o          <= '0;
      dac_set_a_o    <= '0;
      dac_set_b_o    <= '0;
    end
    else if (wr_ok)
    begin
      case (sys_addr_i.f.offset)
        `HK_OFS_LOOP:  digital_loop_o <= sys_wdata_i[0];
        `HK_OFS_LED:   led_o          <= sys_wdata_i[7:0];
        `HK_OFS_DAC_A: dac_set_a_o    <= sys_wdata_i[`ADC_W-1:0];
        `HK_OFS_DAC_B: dac_set_b_o    <= sys_wdata_i[`ADC_W-1:0];
        default:       ;  // id is read-only
      endcase
    end
  end

  // answer one cycle after the enable
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      ack_o <= 1'b0;
      err_o <= 1'b0;
    end
    else
    begin
      ack_o <= wen_i | ren_i;
      err_o <= (ren_i & ~ofs_hit) | (wen_i & ~(ofs_hit & ~ofs_ro));
    end
  end

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      rdata_o <= '0;
    else if (ren_i)
      rdata_o <= rd_word;   // held until the next read
  end

  // one ack per enable, next enable only after the answer
  a_ack_one_cycle : assert property (
    @(posedge adc_clk) disable iff (!rst_n_i)
    (wen_i || ren_i) |=> (ack_o && !(wen_i || ren_i))
  ) else $error("hk ack not exactly one cycle after a single enable");

endmodule

// ==== logic/adc_frontend.sv ====
// ADC input registers, negative-slope to two's complement conversion, loop select
`timescale 1ns/100ps
`include "analog_params.svh"

module adc_frontend (
  input  logic                  adc_clk,
  input  logic                  rst_n_i,
  input  analog_pkg::raw_code_t adc_dat_a_i,
  input  analog_pkg::raw_code_t adc_dat_b_i,
  input  logic                  digital_loop_i,
  input  analog_pkg::sample_t   loop_a_i,      // DAC-side setpoints
  input  analog_pkg::sample_t   loop_b_i,
  output analog_pkg::sample_t   adc_a_o,
  output analog_pkg::sample_t   adc_b_o
);

  import analog_pkg::*;

  // keep sign bit, flip magnitude bits
  function automatic sample_t code_to_sample(input raw_code_t code);
    code_to_sample = {code[`ADC_W-1], ~code[`ADC_W-2:0]};
  endfunction

  sample_t conv_a;
  sample_t conv_b;

  assign conv_a = code_to_sample(adc_dat_a_i);
  assign conv_b = code_to_sample(adc_dat_b_i);

  // pin register, conversion and loop mux share one stage
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      adc_a_o <= '0;
      adc_b_o <= '0;
    end
    else
    begin
      adc_a_o <= digital_loop_i ? loop_a_i : conv_a;  // loopback wins
      adc_b_o <= digital_loop_i ? loop_b_i : conv_b;
    end
  end

endmodule

// ==== logic/dac_backend.sv ====
// DAC code conversion, output registers and half-rate channel interleave
`timescale 1ns/100ps
`include "analog_params.svh"

module dac_backend (
  input  logic                  adc_clk,
  input  logic                  rst_n_i,
  input  analog_pkg::sample_t   dac_a_i,
  input  analog_pkg::sample_t   dac_b_i,
  output analog_pkg::raw_code_t dac_dat_o,   // shared A/B bus
  output logic                  dac_sel_o    // 1 = channel A
);

  import analog_pkg::*;

  // same bit rule as the ADC side, run backwards
  function automatic raw_code_t sample_to_code(input sample_t smp);
    sample_to_code = {smp[`ADC_W-1], ~smp[`ADC_W-2:0]};
  endfunction

  raw_code_t dac_code_a_q;
  raw_code_t dac_code_b_q;
  logic      phase_q;

  ////////////////////////////////////////////////////////////
  // output registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      dac_code_a_q <= '0;   // bus idles at 0 in reset
      dac_code_b_q <= '0;
    end
    else
    begin
      dac_code_a_q <= sample_to_code(dac_a_i);
      dac_code_b_q <= sample_to_code(dac_b_i);
    end
  end

  ////////////////////////////////////////////////////////////
  // interleave
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      phase_q <= 1'b0;
    else
      phase_q <= ~phase_q;  // toggles every cycle
  end

  assign dac_sel_o = phase_q;
  assign dac_dat_o = phase_q ? dac_code_a_q : dac_code_b_q;  // each channel every 2nd cycle

  // first edge out of reset is skipped, select only leaves 0 there
  a_sel_toggles : assert property (
    @(posedge adc_clk) disable iff (!rst_n_i)
    $past(rst_n_i) |-> (dac_sel_o != $past(dac_sel_o))
  ) else $error("dac_sel_o missed a toggle");

endmodule

// ==== logic/analog_top.sv ====
// analog front end top level: bus decoder, housekeeping, ADC and DAC paths
`timescale 1ns/100ps
`include "analog_params.svh"

module analog_top (
  input  logic                  adc_clk,
  input  logic                  rst_n_i,
  // converter pins
  input  analog_pkg::raw_code_t adc_dat_a_i,
  input  analog_pkg::raw_code_t adc_dat_b_i,
  // system bus
  input  analog_pkg::sys_addr_u sys_addr_i,
  input  analog_pkg::bus_word_t sys_wdata_i,
  input  logic                  sys_wen_i,
  input  logic                  sys_ren_i,
  output analog_pkg::bus_word_t sys_rdata_o,
  output logic                  sys_ack_o,
  output logic                  sys_err_o,
  // processed samples
  output analog_pkg::sample_t   adc_a_o,
  output analog_pkg::sample_t   adc_b_o,
  // DAC bus
  output analog_pkg::raw_code_t dac_dat_o,
  output logic                  dac_sel_o,
  output logic [7:0]            led_o
);

  import analog_pkg::*;

  ////////////////////////////////////////////////////////////
  // bus decode
  ////////////////////////////////////////////////////////////

  logic      hk_wen;
  logic      hk_ren;
  bus_word_t hk_rdata;
  logic      hk_ack;
  logic      hk_err;
  logic      digital_loop;
  sample_t   dac_set_a;     // setpoints drive DAC and loopback
  sample_t   dac_set_b;

  bus_decoder bus_decoder_i (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .hk_rdata_i  (hk_rdata),
    .hk_ack_i    (hk_ack),
    .hk_err_i    (hk_err),
    .hk_wen_o    (hk_wen),
    .hk_ren_o    (hk_ren),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o)
  );

  hk_regs hk_regs_i (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .sys_addr_i     (sys_addr_i),   // offset view used inside
    .sys_wdata_i    (sys_wdata_i),
    .wen_i          (hk_wen),
    .ren_i          (hk_ren),
    .rdata_o        (hk_rdata),
    .ack_o          (hk_ack),
    .err_o          (hk_err),
    .digital_loop_o (digital_loop),
    .led_o          (led_o),
    .dac_set_a_o    (dac_set_a),
    .dac_set_b_o    (dac_set_b)
  );

  ////////////////////////////////////////////////////////////
  // analog paths
  ////////////////////////////////////////////////////////////

  adc_frontend adc_frontend_i (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .digital_loop_i (digital_loop),
    .loop_a_i       (dac_set_a),
    .loop_b_i       (dac_set_b),
    .adc_a_o        (adc_a_o),
    .adc_b_o        (adc_b_o)
  );

  dac_backend dac_backend_i (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .dac_a_i   (dac_set_a),
    .dac_b_i   (dac_set_b),
    .dac_dat_o (dac_dat_o),
    .dac_sel_o (dac_sel_o)
  );

endmodule

// ==== sim/analog_top_tb.sv ====
// testbench for analog_top: clock, reset, pattern reader, LFSR samples, compare tasks, report
`timescale 1ns/100ps
`include "analog_params.svh"

module analog_top_tb;

  import analog_pkg::*;

  localparam int ACK_TIMEOUT = 16;  // cycles to wait for sys_ack_o
  localparam raw_code_t LOW_MASK = {1'b0, {(`ADC_W-1){1'b1}}};  // all bits below the top one

  logic      adc_clk;
  logic      rst_n_i;
  raw_code_t adc_dat_a_i;
  raw_code_t adc_dat_b_i;
  sys_addr_u sys_addr_i;
  bus_word_t sys_wdata_i;
  logic      sys_wen_i;
  logic      sys_ren_i;
  bus_word_t sys_rdata_o;
  logic      sys_ack_o;
  logic      sys_err_o;
  sample_t   adc_a_o;
  sample_t   adc_b_o;
  raw_code_t dac_dat_o;
  logic      dac_sel_o;
  logic [7:0] led_o;

  int          value_errors;
  int          timeout_errors;
  int          format_errors;   // unreadable pattern file or line
  logic [15:0] lfsr_state;
  sample_t     set_a;           // setpoints as last written
  sample_t     set_b;

  analog_top analog_top_i (.*);

  initial adc_clk = 1'b0;
  always #4 adc_clk = ~adc_clk;  // 8 ns period

  ////////////////////////////////////////////////////////////
  // expected values and random codes
  ////////////////////////////////////////////////////////////

  // negative-slope code -> two's complement, top bit kept
  function automatic sample_t code_to_twos(input raw_code_t c);
    code_to_twos = sample_t'(c ^ LOW_MASK);
  endfunction

  function automatic raw_code_t twos_to_dac_code(input sample_t s);
    twos_to_dac_code = raw_code_t'(s) ^ LOW_MASK;  // same flip, other way
  endfunction

  function automatic logic [15:0] galois_step(input logic [15:0] s);
    galois_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // x^16+x^14+x^13+x^11+1
  endfunction

  task automatic random_code(output raw_code_t code);
    code = '0;
    for (int b = 0; b < `ADC_W; b++)
    begin
      lfsr_state = galois_step(lfsr_state);    // one step per bit
      code       = {code[`ADC_W-2:0], lfsr_state[0]};
    end
  endtask

  task automatic check_sample(input sample_t got, input sample_t exp, input string what);
    if (got !== exp)
    begin
      value_errors++;
      $display("FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_raw(input raw_code_t got, input raw_code_t exp, input string what);
    if (got !== exp)
    begin
      value_errors++;
      $display("FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_word(input bus_word_t got, input bus_word_t exp, input string what);
    if (got !== exp)
    begin
      value_errors++;
      $display("FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // bus and sample drivers
  ////////////////////////////////////////////////////////////

  task automatic bus_access(input logic is_write, input bus_word_t addr, input bus_word_t wdata,
                            output bus_word_t rdata, output logic err);
    int   cyc;
    logic got;
    got   = 1'b0;
    rdata = '0;
    err   = 1'b0;
    cyc   = 0;
    @(posedge adc_clk);
    sys_addr_i  <= addr;       // held until ack
    sys_wdata_i <= wdata;
    sys_wen_i   <= is_write;
    sys_ren_i   <= ~is_write;
    while (!got && cyc < ACK_TIMEOUT)
    begin
      @(negedge adc_clk);
      if (sys_ack_o)
      begin
        got   = 1'b1;
        rdata = sys_rdata_o;
        err   = sys_err_o;
      end
      else
      begin
        @(posedge adc_clk);
        sys_wen_i <= 1'b0;     // enable is a one-cycle pulse
        sys_ren_i <= 1'b0;
      end
      cyc++;
    end
    if (!got)
    begin
      timeout_errors++;
      $display("timeout: no sys_ack_o within %0d cycles for address %h", ACK_TIMEOUT, addr);
    end
    @(posedge adc_clk);
    sys_wen_i <= 1'b0;
    sys_ren_i <= 1'b0;
  endtask

  // DAC bus carries A while select is high, B while low
  task automatic check_dac_bus();
    if (dac_sel_o)
      check_raw(dac_dat_o, twos_to_dac_code(set_a), "dac_dat_o channel A");
    else
      check_raw(dac_dat_o, twos_to_dac_code(set_b), "dac_dat_o channel B");
  endtask

  task automatic run_adc(input int count, input logic loop_on);
    raw_code_t ca;
    raw_code_t cb;
    logic      sel_before;    // select seen one cycle earlier
    sel_before = 1'b0;
    for (int i = 0; i < count; i++)
    begin
      random_code(ca);
      random_code(cb);
      @(posedge adc_clk);
      adc_dat_a_i <= ca;
      adc_dat_b_i <= cb;
      @(posedge adc_clk);   // DUT samples the pins here
      for (int ph = 0; ph < 2; ph++)  // both select phases
      begin
        @(negedge adc_clk);
        check_sample(adc_a_o, loop_on ? set_a : code_to_twos(ca), "adc_a_o");
        check_sample(adc_b_o, loop_on ? set_b : code_to_twos(cb), "adc_b_o");
        check_dac_bus();
        if (ph == 1)
          check_word({31'b0, dac_sel_o}, {31'b0, ~sel_before}, "dac_sel_o toggle");
        sel_before = dac_sel_o;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // pattern file
  ////////////////////////////////////////////////////////////

  task automatic run_patterns();
    int          fd;
    int          n;
    string       line;
    logic [63:0] op_s;
    bus_word_t   addr;
    bus_word_t   data;
    bus_word_t   expv;
    bus_word_t   rdata;
    logic        err;
    fd = $fopen("sim/analog_patterns.txt", "r");
    if (fd == 0)
    begin
      format_errors++;
      $display("could not open the pattern file sim/analog_patterns.txt");
      return;
    end
    while ($fgets(line, fd) > 0)
    begin
      if (line.len() < 2 || line.getc(0) == 8'h23)
        continue;                                   // blank or comment
      n = $sscanf(line, "%s %h %h %h", op_s, addr, data, expv);
      if (n != 4)
      begin
        format_errors++;
        $display("pattern line could not be parsed: %s", line);
      end
      else if (op_s == "write")
      begin
        bus_access(1'b1, addr, data, rdata, err);
        check_word({31'b0, err}, expv, "sys_err_o on write");
        if (!err && addr == 32'h40)
          set_a = data[`ADC_W-1:0];
        if (!err && addr == 32'h44)
          set_b = data[`ADC_W-1:0];
        if (!err && addr == 32'h30)
          check_word({24'b0, led_o}, {24'b0, data[7:0]}, "led_o");
      end
      else if (op_s == "read")
      begin
        bus_access(1'b0, addr, '0, rdata, err);
        check_word({31'b0, err}, data, "sys_err_o on read");
        check_word(rdata, expv, "sys_rdata_o");
      end
      else if (op_s == "adc")
        run_adc(int'(data), expv[0]);
      else
      begin
        format_errors++;
        $display("unknown operation in pattern line: %s", line);
      end
    end
    $fclose(fd);
  endtask

  initial
  begin
    rst_n_i        = 1'b0;
    adc_dat_a_i    = '0;
    adc_dat_b_i    = '0;
    sys_addr_i     = '0;
    sys_wdata_i    = '0;
    sys_wen_i      = 1'b0;
    sys_ren_i      = 1'b0;
    value_errors   = 0;
    timeout_errors = 0;
    format_errors  = 0;
    lfsr_state     = 16'd45357;
    set_a          = '0;
    set_b          = '0;
    repeat (2) @(posedge adc_clk);   // two cycles in reset
    rst_n_i <= 1'b1;
    @(negedge adc_clk);
    check_raw(dac_dat_o, '0, "dac_dat_o after reset");
    check_word({31'b0, dac_sel_o}, '0, "dac_sel_o after reset");
    check_word({24'b0, led_o}, '0, "led_o after reset");
    run_patterns();
    $display("errors: %0d value, %0d timeout, %0d pattern",
             value_errors, timeout_errors, format_errors);
    if (value_errors + timeout_errors + format_errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// ==== analog_top.f ====
+incdir+logic
logic/analog_pkg.sv
logic/bus_decoder.sv
logic/hk_regs.sv
logic/adc_frontend.sv
logic/dac_backend.sv
logic/analog_top.sv
sim/analog_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the analog_top testbench with Verilator, run it, then check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 \
  --top-module analog_top_tb -f analog_top.f -o analog_top_sim \
  && ./obj_dir/analog_top_sim > sim.log 2>&1 \
  || echo "build or simulation stopped early"
cat sim.log 2>/dev/null
grep -q "Simulation passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== sim/analog_patterns.txt ====
# op     address   data      expect   (all hex)
# write: data = write word, expect = sys_err_o | read: data = sys_err_o, expect = read word
# adc:   data = sample count, expect = 1 when the digital loop is on
read     00000000  0         0A110001
adc      00000000  10        0
write    00000030  000000A5  0
read     00000030  0         000000A5
write    00000040  00001234  0
write    00000044  00002ABC  0
read     00000040  0         00001234
read     00000044  0         00002ABC
write    0000000C  00000001  0
read     0000000C  0         00000001
adc      00000000  10        1
write    0000000C  00000000  0
adc      00000000  10        0
write    00000000  12345678  1
write    00000050  00000001  1
read     00000050  1         00000000
read     00100000  0         00000000
write    00300004  00000055  0
read     00700040  0         00000000
